//--- logic/regfile_issue_pkg.sv
// Sizes are fixed for a 32-entry file with two writeback groups; op encoding is the group number
`default_nettype none

package regfile_issue_pkg;

    //////////////////////////////////////////////////
    // Sizes
    localparam int NUM_REGS       = 32;
    localparam int ADDR_W         = 5;
    localparam int DATA_W         = 32;
    localparam int NUM_READ_PORTS = 2;
    localparam int NUM_WB_GROUPS  = 2;

    //////////////////////////////////////////////////
    // Basic types
    typedef logic [ADDR_W-1:0] reg_addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // Value picks the writeback group as well
    // ADD on group 0, MUL on group 1
    typedef enum logic {
        OP_ADD = 1'b0,
        OP_MUL = 1'b1
    } op_t;

    //////////////////////////////////////////////////
    // Instruction as seen at the input port
    // rs[0] is operand a, rs[1] is operand b
    typedef struct packed {
        reg_addr_t [NUM_READ_PORTS-1:0] rs;
        reg_addr_t                      rd;
        logic                           uses_rd;
        op_t                            op;
    } instr_t;

    // One result per group and cycle
    // Never valid for register 0
    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        data_t     data;
    } wb_packet_t;

endpackage

`default_nettype wire

//--- logic/rf_issue_if.sv
// rs addresses carry the incoming instruction's sources and are only sampled on accept
`timescale 1ns/1ns
`default_nettype none

interface rf_issue_if;

    // Sources of the instruction at the input port
    regfile_issue_pkg::reg_addr_t phys_rs_addr [regfile_issue_pkg::NUM_READ_PORTS];

    // Slot destination, zero when the instruction writes nothing
    regfile_issue_pkg::reg_addr_t phys_rd_addr;
    regfile_issue_pkg::op_t       rd_group;

    // Events
    logic issue;
    logic accept;

    // Slot source state, valid while the slot is full
    logic                     inuse [regfile_issue_pkg::NUM_READ_PORTS];
    regfile_issue_pkg::data_t data  [regfile_issue_pkg::NUM_READ_PORTS];

    modport controller (
        output phys_rs_addr, phys_rd_addr, rd_group, issue, accept,
        input  inuse, data
    );

    modport register_file (
        input  phys_rs_addr, phys_rd_addr, rd_group, issue, accept,
        output inuse, data
    );

endinterface

`default_nettype wire

//--- logic/toggle_memory_set.sv
// Set and clear must not hit the same register in one cycle; reset takes one clocked cycle
`timescale 1ns/1ns
`default_nettype none

module toggle_memory_set #(
    parameter int NUM_TOGGLE_PORTS = 2,
    parameter int NUM_READ_PORTS   = 2
) (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire  [NUM_TOGGLE_PORTS-1:0]       toggle,
    input  wire regfile_issue_pkg::reg_addr_t toggle_addr [NUM_TOGGLE_PORTS],
    input  wire regfile_issue_pkg::reg_addr_t read_addr [NUM_READ_PORTS],
    output logic [NUM_READ_PORTS-1:0]         in_use
);

    // One bit array per toggle port
    // Each array has a single writer, so no port conflicts inside an array
    logic [regfile_issue_pkg::NUM_REGS-1:0] bits [NUM_TOGGLE_PORTS];

    //////////////////////////////////////////////////
    // Toggle banks
    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_TOGGLE_PORTS; p++) begin
            if (!rst_n) begin
                bits[p] <= '0;
            end else if (toggle[p]) begin
                bits[p][toggle_addr[p]] <= ~bits[p][toggle_addr[p]];
            end
        end
    end

    //////////////////////////////////////////////////
    // Read side
    // In use when an odd number of banks flipped the bit
    always_comb begin
        for (int r = 0; r < NUM_READ_PORTS; r++) begin
            in_use[r] = 1'b0;
            for (int p = 0; p < NUM_TOGGLE_PORTS; p++) begin
                in_use[r] = in_use[r] ^ bits[p][read_addr[r]];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/register_bank.sv
// Contents are undefined until written; reads return the value from before a same-edge write
`timescale 1ns/1ns
`default_nettype none

module register_bank #(
    parameter int NUM_READ_PORTS = regfile_issue_pkg::NUM_READ_PORTS
) (
    input  wire                               clk,
    input  wire                               write_en,
    input  wire regfile_issue_pkg::reg_addr_t write_addr,
    input  wire regfile_issue_pkg::data_t     write_data,
    input  wire                               read_en,
    input  wire regfile_issue_pkg::reg_addr_t read_addr [NUM_READ_PORTS],
    output regfile_issue_pkg::data_t          read_data [NUM_READ_PORTS]
);

    // Storage, one inferred memory per instance
    regfile_issue_pkg::data_t mem [regfile_issue_pkg::NUM_REGS];

    // Single write port
    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[write_addr] <= write_data;
        end
    end

    // Registered reads, held until the next accept
    always_ff @(posedge clk) begin
        if (read_en) begin
            for (int i = 0; i < NUM_READ_PORTS; i++) begin
                read_data[i] <= mem[read_addr[i]];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/register_file.sv
// Group 0 results are pending for one cycle only; at most one write per register in flight
`timescale 1ns/1ns
`default_nettype none

module register_file (
    input  wire                                  clk,
    input  wire                                  rst_n,
    rf_issue_if.register_file                    rf,
    input  wire regfile_issue_pkg::wb_packet_t   wb [regfile_issue_pkg::NUM_WB_GROUPS]
);

    localparam int RP = regfile_issue_pkg::NUM_READ_PORTS;
    localparam int WG = regfile_issue_pkg::NUM_WB_GROUPS;

    regfile_issue_pkg::data_t     bank_data [WG][RP];
    regfile_issue_pkg::op_t       group_tbl [regfile_issue_pkg::NUM_REGS];
    regfile_issue_pkg::reg_addr_t rs_r      [RP];
    regfile_issue_pkg::reg_addr_t tog_addr  [2];
    regfile_issue_pkg::reg_addr_t hit_addr  [RP];
    regfile_issue_pkg::data_t     hit_data  [RP];
    regfile_issue_pkg::data_t     cap       [RP];
    logic [1:0]                   tog;
    logic [RP-1:0]                mul_inuse;
    logic [RP-1:0]                hit;
    logic [RP-1:0]                bypass;

    //////////////////////////////////////////////////
    // In-use scoreboard
    // Port 0 sets on MUL issue, port 1 clears on MUL writeback
    // ADD results need no entry, they are pending only in their wb cycle
    assign tog[0]      = rf.issue & (rf.rd_group == regfile_issue_pkg::OP_MUL)
                       & (rf.phys_rd_addr != '0);
    assign tog_addr[0] = rf.phys_rd_addr;
    assign tog[1]      = wb[1].valid & (wb[1].addr != '0);
    assign tog_addr[1] = wb[1].addr;

    toggle_memory_set #(
        .NUM_TOGGLE_PORTS (2),
        .NUM_READ_PORTS   (RP)
    ) inuse_set (
        .clk         (clk),
        .rst_n       (rst_n),
        .toggle      (tog),
        .toggle_addr (tog_addr),
        .read_addr   (rs_r),
        .in_use      (mul_inuse)
    );

    //////////////////////////////////////////////////
    // One bank per writeback group
    for (genvar g = 0; g < WG; g++) begin : bank_gen
        register_bank #(
            .NUM_READ_PORTS (RP)
        ) bank (
            .clk        (clk),
            .write_en   (wb[g].valid),
            .write_addr (wb[g].addr),
            .write_data (wb[g].data),
            .read_en    (rf.accept),
            .read_addr  (rf.phys_rs_addr),
            .read_data  (bank_data[g])
        );
    end

    // Group table, last issued writer of each register
    always_ff @(posedge clk) begin
        if (rf.issue && rf.phys_rd_addr != '0) begin
            group_tbl[rf.phys_rd_addr] <= rf.rd_group;
        end
    end

    //////////////////////////////////////////////////
    // Writeback snoop for each source
    // Incoming sources on accept, slot sources otherwise
    always_comb begin
        for (int i = 0; i < RP; i++) begin
            hit_addr[i] = rf.accept ? rf.phys_rs_addr[i] : rs_r[i];
            hit[i]      = 1'b0;
            hit_data[i] = wb[0].data;
            for (int g = 0; g < WG; g++) begin
                if (wb[g].valid && wb[g].addr == hit_addr[i]) begin
                    hit[i]      = 1'b1;
                    hit_data[i] = wb[g].data;
                end
            end
            // Pending MUL, or an ADD result on the bus this cycle
            rf.inuse[i] = mul_inuse[i] | (wb[0].valid & (wb[0].addr == rs_r[i]));
        end
    end

    // Bank read misses a write on the accept edge, so take it from the bus
    // While pending, keep sampling until the result goes by
    always_ff @(posedge clk) begin
        for (int i = 0; i < RP; i++) begin
            if (rf.accept) begin
                rs_r[i] <= rf.phys_rs_addr[i];
            end
            if (!rst_n) begin
                bypass[i] <= 1'b0;
            end else if (rf.accept) begin
                bypass[i] <= hit[i];
            end else if (rf.inuse[i]) begin
                bypass[i] <= 1'b1;
            end
            if ((rf.accept || rf.inuse[i]) && hit[i]) begin
                cap[i] <= hit_data[i];
            end
        end
    end

    //////////////////////////////////////////////////
    // Operand mux
    always_comb begin
        for (int i = 0; i < RP; i++) begin
            if (rs_r[i] == '0) begin
                rf.data[i] = '0;
            end else if (bypass[i]) begin
                rf.data[i] = cap[i];
            end else begin
                rf.data[i] = bank_data[group_tbl[rs_r[i]]][i];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/issue_control.sv
// Single issue slot; one MUL in flight, so WAW needs only the MUL destination
`timescale 1ns/1ns
`default_nettype none

module issue_control (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               in_valid,
    output logic                              in_ready,
    input  wire regfile_issue_pkg::instr_t    in_instr,
    rf_issue_if.controller                    rf,
    input  wire                               mul_busy,
    output logic                              add_go,
    output logic                              mul_go,
    output regfile_issue_pkg::reg_addr_t      go_rd,
    output logic                              go_uses_rd
);

    typedef enum logic [1:0] {
        EMPTY,
        WAIT_OPERANDS,
        WAIT_UNIT
    } state_t;

    state_t                       state;
    state_t                       state_next;
    regfile_issue_pkg::instr_t    slot;
    regfile_issue_pkg::reg_addr_t mul_rd;
    logic                         is_mul;
    logic                         ops_ready;
    logic                         waw_hit;
    logic                         unit_free;

    //////////////////////////////////////////////////
    // Issue decision
    assign is_mul = (slot.op == regfile_issue_pkg::OP_MUL);

    // Sources stay clear once clear, nothing else issues meanwhile
    always_comb begin
        ops_ready = 1'b1;
        for (int i = 0; i < regfile_issue_pkg::NUM_READ_PORTS; i++) begin
            if (rf.inuse[i]) begin
                ops_ready = 1'b0;
            end
        end
        if (state == WAIT_UNIT) begin
            ops_ready = 1'b1;
        end
    end

    // ADD must not overtake a pending MUL to the same register
    assign waw_hit   = mul_busy & slot.uses_rd & (slot.rd != '0) & (slot.rd == mul_rd);
    assign unit_free = is_mul ? ~mul_busy : ~waw_hit;

    assign rf.issue  = (state != EMPTY) & ops_ready & unit_free;
    assign in_ready  = (state == EMPTY) | rf.issue;
    assign rf.accept = in_valid & in_ready;

    // Bank reads start from the instruction at the port
    always_comb begin
        for (int i = 0; i < regfile_issue_pkg::NUM_READ_PORTS; i++) begin
            rf.phys_rs_addr[i] = in_instr.rs[i];
        end
    end

    assign rf.phys_rd_addr = slot.uses_rd ? slot.rd : '0;
    assign rf.rd_group     = slot.op;

    // Steering to the execution units
    assign add_go     = rf.issue & ~is_mul;
    assign mul_go     = rf.issue & is_mul;
    assign go_rd      = slot.rd;
    assign go_uses_rd = slot.uses_rd;

    //////////////////////////////////////////////////
    // FSM
    always_comb begin
        if (state == EMPTY || rf.issue) begin
            state_next = rf.accept ? WAIT_OPERANDS : EMPTY;
        end else if (ops_ready) begin
            state_next = WAIT_UNIT;
        end else begin
            state_next = WAIT_OPERANDS;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= EMPTY;
        end else begin
            state <= state_next;
        end
    end

    // Slot payload and MUL destination
    always_ff @(posedge clk) begin
        if (rf.accept) begin
            slot <= in_instr;
        end
        if (mul_go) begin
            mul_rd <= slot.rd;
        end
    end

endmodule

`default_nettype wire

//--- logic/latency_timer.sv
// MUL_LATENCY must be 2 or more; a new start is not expected before done
`timescale 1ns/1ns
`default_nettype none

module latency_timer #(
    parameter int MUL_LATENCY = 4
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  start,
    output logic busy,
    output logic done
);

    localparam int CNT_W = $clog2(MUL_LATENCY);

    logic [CNT_W-1:0] count;

    // Count reaches zero in the last cycle of the latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            count <= CNT_W'(MUL_LATENCY - 1);
        end else if (done) begin
            busy  <= 1'b0;
        end else if (busy) begin
            count <= count - 1'b1;
        end
    end

    // One cycle pulse, busy still high here
    assign done = busy & (count == '0);

endmodule

`default_nettype wire

//--- logic/exec_units.sv
// MUL result is valid only in the done cycle; operands are held from mul_go until then
`timescale 1ns/1ns
`default_nettype none

module exec_units (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               add_go,
    input  wire                               mul_go,
    input  wire                               mul_done,
    input  wire regfile_issue_pkg::reg_addr_t go_rd,
    input  wire                               go_uses_rd,
    input  wire regfile_issue_pkg::data_t     operand_a,
    input  wire regfile_issue_pkg::data_t     operand_b,
    output regfile_issue_pkg::wb_packet_t     wb [regfile_issue_pkg::NUM_WB_GROUPS]
);

    regfile_issue_pkg::data_t     mul_a;
    regfile_issue_pkg::data_t     mul_b;
    regfile_issue_pkg::reg_addr_t mul_rd;
    regfile_issue_pkg::data_t     product;
    logic                         mul_writes;

    //////////////////////////////////////////////////
    // ADD, group 0, one cycle after issue
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb[0].valid <= 1'b0;
        end else begin
            wb[0].valid <= add_go & go_uses_rd & (go_rd != '0);
        end
        if (add_go) begin
            wb[0].addr <= go_rd;
            wb[0].data <= operand_a + operand_b;
        end
    end

    //////////////////////////////////////////////////
    // MUL, group 1, operands held for the timer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mul_writes <= 1'b0;
        end else if (mul_go) begin
            mul_writes <= go_uses_rd & (go_rd != '0);
        end
        if (mul_go) begin
            mul_a  <= operand_a;
            mul_b  <= operand_b;
            mul_rd <= go_rd;
        end
    end

    // Low word of the product
    assign product = mul_a * mul_b;

    assign wb[1].valid = mul_done & mul_writes;
    assign wb[1].addr  = mul_rd;
    assign wb[1].data  = product;

endmodule

`default_nettype wire

//--- logic/regfile_issue_top.sv
// Writeback ports are valid-only with no back-pressure; MUL_LATENCY must be 2 or more
`timescale 1ns/1ns
`default_nettype none

module regfile_issue_top #(
    parameter int MUL_LATENCY = 4
) (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               in_valid,
    output logic                              in_ready,
    input  wire regfile_issue_pkg::instr_t    in_instr,
    output logic                              wb0_valid,
    output regfile_issue_pkg::reg_addr_t      wb0_addr,
    output regfile_issue_pkg::data_t          wb0_data,
    output logic                              wb1_valid,
    output regfile_issue_pkg::reg_addr_t      wb1_addr,
    output regfile_issue_pkg::data_t          wb1_data
);

    regfile_issue_pkg::wb_packet_t wb [regfile_issue_pkg::NUM_WB_GROUPS];
    regfile_issue_pkg::reg_addr_t  go_rd;
    logic                          go_uses_rd;
    logic                          add_go;
    logic                          mul_go;
    logic                          mul_busy;
    logic                          mul_done;

    rf_issue_if rf_bus ();

    //////////////////////////////////////////////////
    // Issue side
    issue_control ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_instr   (in_instr),
        .rf         (rf_bus),
        .mul_busy   (mul_busy),
        .add_go     (add_go),
        .mul_go     (mul_go),
        .go_rd      (go_rd),
        .go_uses_rd (go_uses_rd)
    );

    latency_timer #(
        .MUL_LATENCY (MUL_LATENCY)
    ) mul_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .start (mul_go),
        .busy  (mul_busy),
        .done  (mul_done)
    );

    register_file rf0 (
        .clk   (clk),
        .rst_n (rst_n),
        .rf    (rf_bus),
        .wb    (wb)
    );

    // Operands come straight from the register file mux
    exec_units units (
        .clk        (clk),
        .rst_n      (rst_n),
        .add_go     (add_go),
        .mul_go     (mul_go),
        .mul_done   (mul_done),
        .go_rd      (go_rd),
        .go_uses_rd (go_uses_rd),
        .operand_a  (rf_bus.data[0]),
        .operand_b  (rf_bus.data[1]),
        .wb         (wb)
    );

    //////////////////////////////////////////////////
    // Group packets out to the ports
    assign wb0_valid = wb[0].valid;
    assign wb0_addr  = wb[0].addr;
    assign wb0_data  = wb[0].data;
    assign wb1_valid = wb[1].valid;
    assign wb1_addr  = wb[1].addr;
    assign wb1_data  = wb[1].data;

endmodule

`default_nettype wire

//--- verification/regfile_issue_model.svh
// Included inside the testbench module; registers hold zero until preloaded and results are in program order
`ifndef REGFILE_ISSUE_MODEL_SVH
`define REGFILE_ISSUE_MODEL_SVH

//////////////////////////////////////////////////
// Architectural state
regfile_issue_pkg::data_t      model_regs [regfile_issue_pkg::NUM_REGS];

// Expected writebacks, one queue per group
regfile_issue_pkg::wb_packet_t exp_q0 [$];
regfile_issue_pkg::wb_packet_t exp_q1 [$];
int                            expected_results;

// Set while the ADD operand is being seeded
logic                          preloading;

// Seed word, every address bit shows up several times
function automatic regfile_issue_pkg::data_t preload_value(
    input regfile_issue_pkg::reg_addr_t r
);
    return {r, ~r, r, ~r, r, ~r, 2'b10} ^ 32'h6d2b_79f5;
endfunction

function automatic void model_reset();
    for (int i = 0; i < regfile_issue_pkg::NUM_REGS; i++) begin
        model_regs[i] = '0;
    end
    exp_q0.delete();
    exp_q1.delete();
    expected_results = 0;
    preloading       = 1'b0;
endfunction

//////////////////////////////////////////////////
// Sequential execution at acceptance time
function automatic void model_accept(input regfile_issue_pkg::instr_t ins);
    regfile_issue_pkg::data_t      a;
    regfile_issue_pkg::data_t      b;
    regfile_issue_pkg::data_t      res;
    regfile_issue_pkg::wb_packet_t pkt;
    a = model_regs[ins.rs[0]];
    b = model_regs[ins.rs[1]];
    // Seeded operand replaces source a
    if (preloading) begin
        a = preload_value(ins.rd);
    end
    if (ins.op == regfile_issue_pkg::OP_MUL) begin
        res = a * b;
    end else begin
        res = a + b;
    end
    // Register 0 and no-destination ops leave no trace
    if (ins.uses_rd && ins.rd != '0) begin
        model_regs[ins.rd] = res;
        pkt.valid = 1'b1;
        pkt.addr  = ins.rd;
        pkt.data  = res;
        // Op value doubles as the group number
        if (ins.op == regfile_issue_pkg::OP_MUL) begin
            exp_q1.push_back(pkt);
        end else begin
            exp_q0.push_back(pkt);
        end
        expected_results++;
    end
endfunction

`endif

//--- verification/regfile_issue_tb.sv
// MUL_LATENCY here sets the DUT; register contents are seeded by forcing the ADD operand
`timescale 1ns/1ns
`default_nettype none

module regfile_issue_tb;

    typedef regfile_issue_pkg::reg_addr_t reg_addr_t;
    typedef regfile_issue_pkg::data_t     data_t;
    typedef regfile_issue_pkg::instr_t    instr_t;
    typedef regfile_issue_pkg::op_t       op_t;

    localparam int MUL_LATENCY     = 4;
    localparam int NUM_INSTR       = 31 + 40 + 40 + 24 + 40 + 2;
    localparam int WATCHDOG_CYCLES = 20 * (MUL_LATENCY + 2) * NUM_INSTR + 100;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    logic      in_ready;
    instr_t    in_instr;
    logic      wb0_valid;
    reg_addr_t wb0_addr;
    data_t     wb0_data;
    logic      wb1_valid;
    reg_addr_t wb1_addr;
    data_t     wb1_data;
    data_t     boot_word;

    integer seed;
    int     errors;
    int     checks;
    int     tests;
    int     cycle;
    int     wb_total;
    int     wb_seen [2];
    int     last_wb [2];
    int     last_accept;
    int     test_err_start;

    `include "regfile_issue_model.svh"

    regfile_issue_top #(
        .MUL_LATENCY (MUL_LATENCY)
    ) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_instr  (in_instr),
        .wb0_valid (wb0_valid),
        .wb0_addr  (wb0_addr),
        .wb0_data  (wb0_data),
        .wb1_valid (wb1_valid),
        .wb1_addr  (wb1_addr),
        .wb1_data  (wb1_data)
    );

    // Seed follows the slot destination
    assign boot_word = preload_value(dut0.go_rd);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    //////////////////////////////////////////////////
    // Writeback compare
    task automatic check_wb(input int g, input reg_addr_t addr, input data_t data);
        regfile_issue_pkg::wb_packet_t exp;
        wb_total++;
        wb_seen[g]++;
        last_wb[g] = cycle;
        if ((g == 0 && exp_q0.size() == 0) || (g == 1 && exp_q1.size() == 0)) begin
            $display("Unexpected writeback on group %0d at time %0t", g, $time);
            errors++;
        end else begin
            if (g == 0) begin
                exp = exp_q0.pop_front();
            end else begin
                exp = exp_q1.pop_front();
            end
            checks += 2;
            assert (addr == exp.addr) else begin
                $display("Fail time %0t wb%0d_addr expected %0d got %0d",
                         $time, g, exp.addr, addr);
                errors++;
            end
            assert (data == exp.data) else begin
                $display("Fail time %0t wb%0d_data expected %h got %h",
                         $time, g, exp.data, data);
                errors++;
            end
        end
    endtask

    // Transfers feed the model, pulses pop it
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (rst_n) begin
            if (in_valid && in_ready) begin
                model_accept(in_instr);
                last_accept = cycle;
            end
            if (wb0_valid) begin
                check_wb(0, wb0_addr, wb0_data);
            end
            if (wb1_valid) begin
                check_wb(1, wb1_addr, wb1_data);
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus helpers
    function automatic reg_addr_t pick_reg();
        return reg_addr_t'($unsigned($random(seed)) % 31 + 1);
    endfunction

    function automatic op_t pick_op();
        return ($random(seed) & 1) ? regfile_issue_pkg::OP_MUL : regfile_issue_pkg::OP_ADD;
    endfunction

    function automatic instr_t make_instr(input op_t op, input reg_addr_t rs0,
                                          input reg_addr_t rs1, input reg_addr_t rd,
                                          input logic uses_rd);
        instr_t ins;
        ins.rs[0]   = rs0;
        ins.rs[1]   = rs1;
        ins.rd      = rd;
        ins.uses_rd = uses_rd;
        ins.op      = op;
        return ins;
    endfunction

    // Entered and left 1 ns after a rising edge
    task automatic send_instr(input instr_t ins);
        in_valid = 1'b1;
        in_instr = ins;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
        #1;
        in_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Drain results, then let the timer run out
    task automatic wait_idle();
        while (exp_q0.size() + exp_q1.size() != 0) begin
            idle(1);
        end
        idle(MUL_LATENCY + 3);
    endtask

    task automatic check_counts();
        checks++;
        assert (wb_total == expected_results) else begin
            $display("Fail time %0t wb_pulse_count expected %0d got %0d",
                     $time, expected_results, wb_total);
            errors++;
        end
    endtask

    task automatic start_test();
        test_err_start = errors;
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == test_err_start) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errors - test_err_start);
        end
    endtask

    // Transfer to pulse, counted in edges
    task automatic measure_latency(input op_t op, input int want);
        instr_t ins;
        int     g;
        int     start_seen;
        int     sent;
        int     waited;
        g = (op == regfile_issue_pkg::OP_MUL) ? 1 : 0;
        wait_idle();
        ins        = make_instr(op, pick_reg(), pick_reg(), pick_reg(), 1'b1);
        start_seen = wb_seen[g];
        send_instr(ins);
        sent   = last_accept;
        waited = 0;
        while (wb_seen[g] == start_seen && waited < 4 * want) begin
            idle(1);
            waited++;
        end
        if (wb_seen[g] == start_seen) begin
            $display("No writeback on group %0d within %0d cycles of the transfer",
                     g, 4 * want);
            errors++;
        end else begin
            checks++;
            assert (last_wb[g] - sent == want) else begin
                $display("Fail time %0t wb%0d_latency expected %0d got %0d",
                         $time, g, want, last_wb[g] - sent);
                errors++;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    initial begin
        instr_t    ins;
        reg_addr_t prev;
        reg_addr_t rd;
        reg_addr_t rs0;
        reg_addr_t rs1;
        int        kind;
        seed        = 91361;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        cycle       = 0;
        wb_total    = 0;
        wb_seen[0]  = 0;
        wb_seen[1]  = 0;
        last_wb[0]  = 0;
        last_wb[1]  = 0;
        last_accept = 0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_instr    = '0;
        model_reset();
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Idle after reset
        start_test();
        idle(5);
        checks += 2;
        assert (in_ready === 1'b1) else begin
            $display("Fail time %0t in_ready expected 1 got %b", $time, in_ready);
            errors++;
        end
        assert (wb_total == 0) else begin
            $display("Fail time %0t wb_pulse_count expected 0 got %0d", $time, wb_total);
            errors++;
        end
        finish_test("reset state");

        // Seed every register through the ADD path
        start_test();
        force dut0.units.operand_a = boot_word;
        preloading = 1'b1;
        for (int r = 1; r < regfile_issue_pkg::NUM_REGS; r++) begin
            send_instr(make_instr(regfile_issue_pkg::OP_ADD, '0, '0, reg_addr_t'(r), 1'b1));
        end
        wait_idle();
        preloading = 1'b0;
        release dut0.units.operand_a;
        finish_test("register preload");

        // Sources never equal the destination
        start_test();
        for (int i = 0; i < 40; i++) begin
            rd  = pick_reg();
            rs0 = pick_reg();
            while (rs0 == rd) rs0 = pick_reg();
            rs1 = pick_reg();
            while (rs1 == rd || rs1 == rs0) rs1 = pick_reg();
            send_instr(make_instr(pick_op(), rs0, rs1, rd, 1'b1));
        end
        wait_idle();
        finish_test("independent operations");

        // Chains over a few registers for RAW and WAW
        start_test();
        prev = pick_reg();
        for (int i = 0; i < 40; i++) begin
            rd = reg_addr_t'($unsigned($random(seed)) % 4 + 1);
            send_instr(make_instr(pick_op(), prev, pick_reg(), rd, 1'b1));
            prev = rd;
        end
        wait_idle();
        finish_test("dependency stalls");

        // No destination, destination 0, or source 0
        start_test();
        for (int i = 0; i < 24; i++) begin
            kind = $unsigned($random(seed)) % 3;
            if (kind == 0) begin
                ins = make_instr(pick_op(), pick_reg(), pick_reg(), pick_reg(), 1'b0);
            end else if (kind == 1) begin
                ins = make_instr(pick_op(), pick_reg(), pick_reg(), '0, 1'b1);
            end else begin
                ins = make_instr(pick_op(), '0, pick_reg(), pick_reg(), 1'b1);
            end
            send_instr(ins);
        end
        wait_idle();
        check_counts();
        finish_test("register zero");

        // Bursts with idle cycles in between
        start_test();
        for (int i = 0; i < 40; i++) begin
            idle($unsigned($random(seed)) % 4);
            ins = make_instr(pick_op(), reg_addr_t'($random(seed)), reg_addr_t'($random(seed)),
                             reg_addr_t'($random(seed)), ($random(seed) % 4) != 0);
            send_instr(ins);
        end
        wait_idle();
        check_counts();
        finish_test("input gaps");

        start_test();
        measure_latency(regfile_issue_pkg::OP_MUL, MUL_LATENCY + 1);
        measure_latency(regfile_issue_pkg::OP_ADD, 2);
        finish_test("fixed latency");

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Hang guard
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles with results still missing", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- regfile_issue.f
+incdir+verification
logic/regfile_issue_pkg.sv
logic/rf_issue_if.sv
logic/toggle_memory_set.sv
logic/register_bank.sv
logic/register_file.sv
logic/issue_control.sv
logic/latency_timer.sv
logic/exec_units.sv
logic/regfile_issue_top.sv
verification/regfile_issue_tb.sv
